// ==== all.f ====
+incdir+verilog
+incdir+test
verilog/rtc_reg_pkg.sv
verilog/ui_pkg.sv
verilog/button_pulser.sv
verilog/init_sequencer.sv
verilog/field_editor.sv
verilog/rtc_setter_top.sv
test/tb_top.sv

// ==== test/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// register addresses in the order right steps through them
logic [7:0] field_order [8] = '{8'h21, 8'h22, 8'h23, 8'h24, 8'h25, 8'h26, 8'h27, 8'h28};

function automatic buttons_t make_buttons(input bit up, input bit down,
                                          input bit left, input bit right);
  buttons_t b;
  b.up    = up;
  b.down  = down;
  b.left  = left;
  b.right = right;
  return b;
endfunction

task automatic stop_run();
  $display("TESTS FAILED");
  $fatal(1, "run stopped at first error");
endtask

task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                           input string what);
  if (actual !== expected)
  begin
    $display("Mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, what, actual, expected);
    stop_run();
  end
endtask

// no write may appear and the field must hold
task automatic watch_quiet(input int cycles, input logic [7:0] exp_field);
  for (int i = 0; i < cycles; i++)
  begin
    @(negedge clk);
    if (wr_o.valid)
    begin
      $display("Unexpected register write to 0x%0h at %0t", wr_o.addr, $time);
      stop_run();
    end
    check_value(field_o, exp_field, "field_o with no field change");
  end
endtask

// cycles counts rising edges from the call to the write
task automatic wait_write(input int limit, output rtc_write_t w, output int cycles);
  bit seen;
  seen   = 1'b0;
  cycles = 0;
  w      = '0;
  while (!seen && cycles <= limit)
  begin
    @(negedge clk);
    if (wr_o.valid)
    begin
      seen = 1'b1;
      w    = wr_o;
    end
    else
      cycles++;
  end
  if (!seen)
  begin
    $display("Timed out after %0d cycles waiting for a register write", limit);
    stop_run();
  end
endtask

task automatic wait_ready(input int limit, output int cycles);
  bit up;
  up     = 1'b0;
  cycles = 0;
  while (!up && cycles < limit)
  begin
    @(negedge clk);
    if (wr_o.valid)
    begin
      $display("Unexpected register write during settle wait at %0t", $time);
      stop_run();
    end
    up = ready_o;
    cycles++;
  end
  if (!up)
  begin
    $display("Timed out after %0d cycles waiting for ready_o", limit);
    stop_run();
  end
endtask

task automatic release_buttons(input logic [7:0] exp_field);
  @(posedge clk);
  buttons_i <= '0;
  watch_quiet(4, exp_field);
endtask

task automatic press_for_write(input buttons_t b, input logic [7:0] exp_field,
                               input logic [7:0] exp_data);
  rtc_write_t w;
  int         cycles;
  @(posedge clk);
  buttons_i <= b;
  wait_write(`PRESS_CYCLES + 10, w, cycles);
  check_value(cycles, `PRESS_CYCLES + 1, "write delay after press");
  check_value(w.addr, exp_field, "write address");
  check_value(w.data, exp_data, "write data");
  watch_quiet(40, exp_field);  // one write only while still held
  release_buttons(exp_field);
endtask

task automatic press_for_field(input buttons_t b, input logic [7:0] from_field,
                               input logic [7:0] exp_field);
  bit moved;
  int cycles;
  moved  = 1'b0;
  cycles = 0;
  @(posedge clk);
  buttons_i <= b;
  while (!moved && cycles <= `PRESS_CYCLES + 10)
  begin
    @(negedge clk);
    if (wr_o.valid)
    begin
      $display("Unexpected register write while changing field at %0t", $time);
      stop_run();
    end
    if (field_o !== from_field)
      moved = 1'b1;
    else
      cycles++;
  end
  if (!moved)
  begin
    $display("Timed out waiting for field_o to leave 0x%0h", from_field);
    stop_run();
  end
  check_value(cycles, `PRESS_CYCLES + 1, "field change delay after press");
  check_value(field_o, exp_field, "field_o after press");
  watch_quiet(20, exp_field);
  release_buttons(exp_field);
endtask

task automatic press_for_nothing(input buttons_t b, input int hold,
                                 input logic [7:0] exp_field);
  @(posedge clk);
  buttons_i <= b;
  watch_quiet(hold, exp_field);
  release_buttons(exp_field);
endtask

task automatic check_after_reset();
  @(negedge clk);
  check_value(wr_o.valid, 1'b0, "wr_o valid after reset");
  check_value(ready_o, 1'b0, "ready_o after reset");
  check_value(rtc_reset_o, 1'b0, "rtc_reset_o after reset");
  check_value(field_o, 8'h21, "field_o after reset");
endtask

task automatic run_power_up();
  rtc_write_t w;
  int         cycles;
  @(posedge clk);
  start_i <= 1'b1;
  wait_write(8, w, cycles);
  // one cycle to see start and one for the registered write bus
  check_value(cycles, 2, "stop write delay after start");
  check_value(w.addr, `RTC_CTRL_ADDR, "stop write address");
  check_value(w.data, `RTC_CTRL_STOP, "stop write data");
  check_value(rtc_reset_o, 1'b1, "rtc_reset_o at stop write");
  watch_quiet(6, 8'h21);
  check_value(rtc_reset_o, 1'b1, "rtc_reset_o while start held");
  @(posedge clk);
  start_i <= 1'b0;
  wait_write(8, w, cycles);
  check_value(cycles, 2, "run write delay after release");
  check_value(w.addr, `RTC_CTRL_ADDR, "run write address");
  check_value(w.data, `RTC_CTRL_RUN, "run write data");
  check_value(rtc_reset_o, 1'b1, "rtc_reset_o at run write");
  wait_ready(`INIT_CYCLES + 20, cycles);
  // settle time runs from the run write on init_wr which wr_o shows a cycle later
  check_value(cycles, `INIT_CYCLES - 1, "ready_o delay after run write");
  check_value(rtc_reset_o, 1'b0, "rtc_reset_o after settle");
  watch_quiet(4, 8'h21);
endtask

task automatic adjust_seconds();
  @(posedge clk);
  cur_time = {$urandom, $urandom};
  time_i <= cur_time;
  edit_i <= 1'b1;
  press_for_write(make_buttons(1, 0, 0, 0), 8'h21, cur_time.seconds + 8'd1);
  press_for_write(make_buttons(0, 1, 0, 0), 8'h21, cur_time.seconds - 8'd1);
endtask

task automatic step_through_fields();
  for (int i = 0; i < 8; i++)
    press_for_field(make_buttons(0, 0, 0, 1), field_order[i], field_order[(i + 1) % 8]);
  press_for_field(make_buttons(0, 0, 1, 0), 8'h21, 8'h28);  // wraps backwards
  press_for_write(make_buttons(1, 0, 0, 0), 8'h28, cur_time.week_num + 8'd1);
endtask

task automatic ignore_blocked_presses();
  @(posedge clk);
  edit_i <= 1'b0;
  press_for_nothing(make_buttons(1, 0, 0, 0), `PRESS_CYCLES + 20, 8'h28);
  press_for_nothing(make_buttons(0, 0, 0, 1), `PRESS_CYCLES + 20, 8'h28);
  @(posedge clk);
  edit_i <= 1'b1;
  press_for_nothing(make_buttons(1, 0, 0, 0), `PRESS_CYCLES - 10, 8'h28);  // too short
  press_for_nothing(make_buttons(1, 1, 0, 0), `PRESS_CYCLES + 20, 8'h28);
endtask

`endif

// ==== test/tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rtc_defs.svh"

module tb_top;

  import rtc_reg_pkg::*;
  import ui_pkg::*;

  logic       clk;
  logic       reset_i;
  logic       start_i;
  logic       edit_i;
  buttons_t   buttons_i;
  rtc_time_t  time_i;
  rtc_write_t wr_o;
  logic       rtc_reset_o;
  rtc_field_e field_o;
  logic       ready_o;

  rtc_time_t  cur_time;  // what the chip side reads back

  rtc_setter_top dut_i (
    .clk         (clk),
    .reset_i     (reset_i),
    .start_i     (start_i),
    .edit_i      (edit_i),
    .buttons_i   (buttons_i),
    .time_i      (time_i),
    .wr_o        (wr_o),
    .rtc_reset_o (rtc_reset_o),
    .field_o     (field_o),
    .ready_o     (ready_o)
  );

  always #4 clk = ~clk;  // 8 ns period

  `include "tb_tasks.svh"

  initial
  begin
    clk       = 1'b0;
    reset_i   = 1'b1;
    start_i   = 1'b0;
    edit_i    = 1'b0;
    buttons_i = '0;
    time_i    = '0;
    cur_time  = '0;
    void'($urandom(25));
    repeat (4) @(posedge clk);
    reset_i <= 1'b0;

    check_after_reset();
    run_power_up();
    adjust_seconds();
    step_through_fields();
    ignore_blocked_presses();

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/button_pulser.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rtc_defs.svh"

module button_pulser (
  input  wire              clk,
  input  wire              reset_i,
  input  wire ui_pkg::buttons_t buttons_i,
  output ui_pkg::buttons_t press_o
);

  localparam int CNT_W = $clog2(`PRESS_CYCLES);

  logic [CNT_W-1:0] hold_cnt;
  logic             armed;  // cleared once a press has fired
  logic             any_held;

  assign any_held = |buttons_i;

  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      hold_cnt <= '0;
      armed    <= 1'b1;
      press_o  <= '0;
    end
    else
    begin
      press_o <= '0;
      if (!any_held)
      begin
        hold_cnt <= '0;  // full release rearms
        armed    <= 1'b1;
      end
      else if (armed)
      begin
        if (hold_cnt == CNT_W'(`PRESS_CYCLES - 1))
        begin
          press_o  <= buttons_i;  // everything held right now
          armed    <= 1'b0;
          hold_cnt <= '0;
        end
        else
        begin
          hold_cnt <= hold_cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/field_editor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rtc_defs.svh"

module field_editor (
  input  wire                          clk,
  input  wire                          reset_i,
  input  wire                          busy_i,
  input  wire                          edit_i,
  input  wire ui_pkg::buttons_t        press_i,
  input  wire rtc_reg_pkg::rtc_time_t  time_i,
  input  wire rtc_reg_pkg::rtc_write_t init_wr_i,
  output rtc_reg_pkg::rtc_write_t      wr_o,
  output rtc_reg_pkg::rtc_field_e      field_o
);

  import rtc_reg_pkg::*;
  import ui_pkg::*;

  edit_state_e            state;
  logic [`RTC_DATA_W-1:0] cur_val;  // read-back value of the selected field
  rtc_field_e             field_next;
  rtc_field_e             field_prev;
  logic                   do_up;
  logic                   do_down;
  logic                   do_left;
  logic                   do_right;

  // opposing pairs cancel
  assign do_up    = press_i.up && !press_i.down;
  assign do_down  = press_i.down && !press_i.up;
  assign do_left  = press_i.left && !press_i.right;
  assign do_right = press_i.right && !press_i.left;

  always_comb
  begin
    case (field_o)
      field_seconds: cur_val = time_i.seconds;
      field_minutes: cur_val = time_i.minutes;
      field_hours:   cur_val = time_i.hours;
      field_date:    cur_val = time_i.date;
      field_month:   cur_val = time_i.month;
      field_year:    cur_val = time_i.year;
      field_weekday: cur_val = time_i.weekday;
      field_week:    cur_val = time_i.week_num;
      default:       cur_val = time_i.seconds;
    endcase
  end

  // neighbours in address order wrap at both ends
  always_comb
  begin
    if (field_o == field_week)
    begin
      field_next = field_seconds;
    end
    else
    begin
      field_next = rtc_field_e'(field_o + 8'd1);
    end
    if (field_o == field_seconds)
    begin
      field_prev = field_week;
    end
    else
    begin
      field_prev = rtc_field_e'(field_o - 8'd1);
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      state      <= edit_waiting;
      field_o    <= field_seconds;
      wr_o.valid <= 1'b0;
    end
    else
    begin
      wr_o.valid <= 1'b0;
      if (busy_i)
      begin
        // also catches a restart while editing
        state   <= edit_waiting;
        field_o <= field_seconds;
        wr_o    <= init_wr_i;
      end
      else if (state == edit_waiting)
      begin
        state <= edit_editing;
      end
      else if (edit_i)
      begin
        if (do_up || do_down)
        begin
          wr_o.valid <= 1'b1;
          wr_o.addr  <= field_o;
          wr_o.data  <= do_up ? cur_val + 1'b1 : cur_val - 1'b1;  // wraps mod 256
        end
        if (do_right)
        begin
          field_o <= field_next;
        end
        else if (do_left)
        begin
          field_o <= field_prev;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/init_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rtc_defs.svh"

module init_sequencer (
  input  wire                     clk,
  input  wire                     reset_i,
  input  wire                     start_i,
  output rtc_reg_pkg::rtc_write_t init_wr_o,
  output logic                    busy_o,
  output logic                    rtc_reset_o
);

  import ui_pkg::*;

  localparam int CNT_W = $clog2(`INIT_CYCLES);

  init_state_e      state;
  logic             start_q;
  logic             start_rise;
  logic [CNT_W-1:0] settle_cnt;

  assign start_rise = start_i && !start_q;

  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      state           <= init_idle;
      start_q         <= 1'b0;
      settle_cnt      <= '0;
      init_wr_o.valid <= 1'b0;
    end
    else
    begin
      start_q         <= start_i;
      init_wr_o.valid <= 1'b0;
      if (start_rise)
      begin
        // a new start begins again with the stop write from any state
        state           <= init_stopping;
        init_wr_o.valid <= 1'b1;
        init_wr_o.addr  <= `RTC_CTRL_ADDR;
        init_wr_o.data  <= `RTC_CTRL_STOP;
      end
      else
      begin
        case (state)
          init_stopping:
          begin
            if (!start_i)
            begin
              state           <= init_settling;
              settle_cnt      <= '0;
              init_wr_o.valid <= 1'b1;
              init_wr_o.addr  <= `RTC_CTRL_ADDR;
              init_wr_o.data  <= `RTC_CTRL_RUN;
            end
          end
          init_settling:
          begin
            if (settle_cnt == CNT_W'(`INIT_CYCLES - 1))
            begin
              state <= init_done;
            end
            settle_cnt <= settle_cnt + 1'b1;
          end
          default:
          begin
            state <= state;  // idle and done wait for start
          end
        endcase
      end
    end
  end

  assign busy_o      = (state != init_done);
  assign rtc_reset_o = (state == init_stopping) || (state == init_settling);

endmodule

`default_nettype wire

// ==== verilog/rtc_defs.svh ====
`ifndef RTC_DEFS_SVH
`define RTC_DEFS_SVH

// register bus widths
`define RTC_DATA_W 8

// control register and its two init values
`define RTC_CTRL_ADDR 8'h02
`define RTC_CTRL_STOP 8'h10
`define RTC_CTRL_RUN  8'h00

`define PRESS_CYCLES 74   // cycles a button must be held to count
`define INIT_CYCLES  222  // settle wait after start is released

`endif

// ==== verilog/rtc_reg_pkg.sv ====
`default_nettype none

`include "rtc_defs.svh"

package rtc_reg_pkg;

  typedef logic [7:0] rtc_addr_t;
  typedef logic [`RTC_DATA_W-1:0] rtc_data_t;

  // each editable field's value is its register address on the chip
  typedef enum logic [7:0] {
    field_seconds = 8'h21,
    field_minutes = 8'h22,
    field_hours   = 8'h23,
    field_date    = 8'h24,
    field_month   = 8'h25,
    field_year    = 8'h26,
    field_weekday = 8'h27,
    field_week    = 8'h28
  } rtc_field_e;

  // values read back from the chip with seconds in the top byte
  typedef struct packed {
    rtc_data_t seconds;
    rtc_data_t minutes;
    rtc_data_t hours;
    rtc_data_t date;
    rtc_data_t month;
    rtc_data_t year;
    rtc_data_t weekday;
    rtc_data_t week_num;
  } rtc_time_t;

  // one register write per cycle with valid high
  typedef struct packed {
    logic      valid;
    rtc_addr_t addr;
    rtc_data_t data;
  } rtc_write_t;

endpackage

`default_nettype wire

// ==== verilog/rtc_setter_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rtc_setter_top (
  input  wire                         clk,
  input  wire                         reset_i,
  input  wire                         start_i,
  input  wire                         edit_i,
  input  wire ui_pkg::buttons_t       buttons_i,
  input  wire rtc_reg_pkg::rtc_time_t time_i,
  output rtc_reg_pkg::rtc_write_t     wr_o,
  output logic                        rtc_reset_o,
  output rtc_reg_pkg::rtc_field_e     field_o,
  output logic                        ready_o
);

  import rtc_reg_pkg::*;
  import ui_pkg::*;

  buttons_t   press;    // one-cycle pulse per press
  rtc_write_t init_wr;
  logic       busy;

  button_pulser u_button_pulser (
    .clk       (clk),
    .reset_i   (reset_i),
    .buttons_i (buttons_i),
    .press_o   (press)
  );

  init_sequencer u_init_sequencer (
    .clk         (clk),
    .reset_i     (reset_i),
    .start_i     (start_i),
    .init_wr_o   (init_wr),
    .busy_o      (busy),
    .rtc_reset_o (rtc_reset_o)
  );

  field_editor u_field_editor (
    .clk       (clk),
    .reset_i   (reset_i),
    .busy_i    (busy),
    .edit_i    (edit_i),
    .press_i   (press),
    .time_i    (time_i),
    .init_wr_i (init_wr),
    .wr_o      (wr_o),
    .field_o   (field_o)
  );

  assign ready_o = ~busy;

endmodule

`default_nettype wire

// ==== verilog/ui_pkg.sv ====
`default_nettype none

package ui_pkg;

  // push buttons as raw levels or one-cycle pulses
  typedef struct packed {
    logic up;
    logic down;
    logic left;
    logic right;
  } buttons_t;

  // power-up sequence of the control register
  typedef enum logic [1:0] {
    init_idle,      // waiting for start
    init_stopping,  // stop written while start is held
    init_settling,  // run written and settle time counting
    init_done
  } init_state_e;

  // field editor
  typedef enum logic {
    edit_waiting,  // writes come from the sequencer during init
    edit_editing
  } edit_state_e;

endpackage

`default_nettype wire
